// ==== build.f ====
rtl/mshr_cfg_pkg.sv
rtl/mshr_types_pkg.sv
rtl/mshr_mem_if.sv
rtl/mshr_regbank.sv
rtl/mshr.sv
rtl/miss_ctrl.sv
rtl/miss_unit_top.sv
tests/tb_miss_unit.sv

// ==== rtl/miss_ctrl.sv ====
// Miss controller that turns a miss strobe into check then allocate and reports the outcome
`default_nettype none

module miss_ctrl #(
    parameter  int unsigned SETS        = mshr_cfg_pkg::MSHR_SETS,
    parameter  int unsigned WAYS        = mshr_cfg_pkg::MSHR_WAYS,
    localparam int unsigned NLINE_WIDTH = mshr_cfg_pkg::NLINE_WIDTH,
    localparam int unsigned ID_WIDTH    = mshr_cfg_pkg::REQ_ID_WIDTH,
    localparam int unsigned SET_WIDTH   = $clog2(SETS),
    localparam int unsigned TAG_WIDTH   = NLINE_WIDTH - SET_WIDTH,
    localparam int unsigned WAY_WIDTH   = (WAYS > 1) ? $clog2(WAYS) : 1
) (
    input  wire logic                    clk_i,
    input  wire logic                    rst_ni,
    input  wire logic                    miss_req_i,
    input  wire logic [NLINE_WIDTH-1:0]  miss_nline_i,
    input  wire logic [ID_WIDTH-1:0]     miss_id_i,
    output logic                         busy_o,
    output logic                         check_o,
    output logic [SET_WIDTH-1:0]         check_set_o,
    output logic [TAG_WIDTH-1:0]         check_tag_o,
    input  wire logic                    hit_i,
    input  wire logic                    alloc_full_i,
    input  wire logic [WAY_WIDTH-1:0]    alloc_way_i,
    output logic                         alloc_o,
    output logic [NLINE_WIDTH-1:0]       alloc_nline_o,
    output logic [ID_WIDTH-1:0]          alloc_id_o,
    output logic                         done_o,
    output mshr_types_pkg::miss_status_e status_o,
    output logic [WAY_WIDTH-1:0]         way_o
);

    mshr_types_pkg::miss_state_e state_q;
    mshr_types_pkg::miss_state_e state_d;
    logic [NLINE_WIDTH-1:0]      nline_q;
    logic [ID_WIDTH-1:0]         id_q;

    // Captured line split into set and tag
    assign check_set_o   = nline_q[SET_WIDTH-1:0];
    assign check_tag_o   = nline_q[NLINE_WIDTH-1:SET_WIDTH];
    assign check_o       = (state_q == mshr_types_pkg::CHECK);
    assign alloc_o       = (state_q == mshr_types_pkg::DECIDE) && !hit_i && !alloc_full_i;
    assign alloc_nline_o = nline_q;
    assign alloc_id_o    = id_q;

    // Busy from the strobe until done
    assign busy_o = miss_req_i || (state_q != mshr_types_pkg::IDLE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            mshr_types_pkg::IDLE:   if (miss_req_i) state_d = mshr_types_pkg::CHECK;
            mshr_types_pkg::CHECK:  state_d = mshr_types_pkg::DECIDE;
            mshr_types_pkg::DECIDE: state_d = mshr_types_pkg::IDLE;
            default:                state_d = mshr_types_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= mshr_types_pkg::IDLE;
            done_o  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_o  <= (state_q == mshr_types_pkg::DECIDE);
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == mshr_types_pkg::IDLE) && miss_req_i) begin
            nline_q <= miss_nline_i;
            id_q    <= miss_id_i;
        end
        // Pending line wins over a full set
        if (state_q == mshr_types_pkg::DECIDE) begin
            status_o <= hit_i ? mshr_types_pkg::MISS_HIT :
                        (alloc_full_i ? mshr_types_pkg::MISS_FULL : mshr_types_pkg::MISS_ALLOC);
            way_o    <= alloc_way_i;
        end
    end

    req_in_idle_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        miss_req_i |-> (state_q == mshr_types_pkg::IDLE)
    ) else $error("Miss request while the controller is busy");

endmodule

`default_nettype wire

// ==== rtl/miss_unit_top.sv ====
// Miss unit top level: miss controller, MSHR and its entry bank
`default_nettype none

module miss_unit_top #(
    parameter  int unsigned SETS        = mshr_cfg_pkg::MSHR_SETS,
    parameter  int unsigned WAYS        = mshr_cfg_pkg::MSHR_WAYS,
    localparam int unsigned NLINE_WIDTH = mshr_cfg_pkg::NLINE_WIDTH,
    localparam int unsigned ID_WIDTH    = mshr_cfg_pkg::REQ_ID_WIDTH,
    localparam int unsigned SET_WIDTH   = $clog2(SETS),
    localparam int unsigned TAG_WIDTH   = NLINE_WIDTH - SET_WIDTH,
    localparam int unsigned WAY_WIDTH   = (WAYS > 1) ? $clog2(WAYS) : 1
) (
    input  wire logic                    clk_i,
    input  wire logic                    rst_ni,
    input  wire logic                    miss_req_i,
    input  wire logic [NLINE_WIDTH-1:0]  miss_nline_i,
    input  wire logic [ID_WIDTH-1:0]     miss_id_i,
    output logic                         busy_o,
    output logic                         done_o,
    output mshr_types_pkg::miss_status_e status_o,
    output logic [WAY_WIDTH-1:0]         way_o,
    input  wire logic                    refill_i,
    input  wire logic [SET_WIDTH-1:0]    refill_set_i,
    input  wire logic [WAY_WIDTH-1:0]    refill_way_i,
    output logic                         ack_valid_o,
    output logic [NLINE_WIDTH-1:0]       ack_nline_o,
    output logic [ID_WIDTH-1:0]          ack_id_o,
    output logic                         empty_o,
    output logic                         full_o
);

    logic                   check;
    logic [SET_WIDTH-1:0]   check_set;
    logic [TAG_WIDTH-1:0]   check_tag;
    logic                   hit;
    logic                   alloc;
    logic [NLINE_WIDTH-1:0] alloc_nline;
    logic [ID_WIDTH-1:0]    alloc_id;
    logic                   alloc_full;
    logic [WAY_WIDTH-1:0]   alloc_way;

    mshr_mem_if #(.SETS(SETS), .WAYS(WAYS)) u_mem_if ();

    miss_ctrl #(.SETS(SETS), .WAYS(WAYS)) u_miss_ctrl (
        .clk_i, .rst_ni,
        .miss_req_i, .miss_nline_i, .miss_id_i, .busy_o,
        .check_o(check), .check_set_o(check_set), .check_tag_o(check_tag),
        .hit_i(hit), .alloc_full_i(alloc_full), .alloc_way_i(alloc_way),
        .alloc_o(alloc), .alloc_nline_o(alloc_nline), .alloc_id_o(alloc_id),
        .done_o, .status_o, .way_o
    );

    mshr #(.SETS(SETS), .WAYS(WAYS)) u_mshr (
        .clk_i, .rst_ni,
        .check_i(check), .check_set_i(check_set), .check_tag_i(check_tag), .hit_o(hit),
        .alloc_i(alloc), .alloc_nline_i(alloc_nline), .alloc_id_i(alloc_id),
        .alloc_full_o(alloc_full), .alloc_way_o(alloc_way),
        .ack_i(refill_i), .ack_set_i(refill_set_i), .ack_way_i(refill_way_i),
        .ack_valid_o, .ack_nline_o, .ack_id_o,
        .empty_o, .full_o,
        .mem(u_mem_if.ctrl)
    );

    mshr_regbank #(.SETS(SETS), .WAYS(WAYS)) u_regbank (
        .clk_i, .rst_ni,
        .mem(u_mem_if.mem)
    );

endmodule

`default_nettype wire

// ==== rtl/mshr.sv ====
// MSHR control: valid bits, free-way search, pending-line hit, port select, refill read-out
`default_nettype none

module mshr #(
    parameter  int unsigned SETS        = mshr_cfg_pkg::MSHR_SETS,
    parameter  int unsigned WAYS        = mshr_cfg_pkg::MSHR_WAYS,
    localparam int unsigned NLINE_WIDTH = mshr_cfg_pkg::NLINE_WIDTH,
    localparam int unsigned ID_WIDTH    = mshr_cfg_pkg::REQ_ID_WIDTH,
    localparam int unsigned SET_WIDTH   = $clog2(SETS),
    localparam int unsigned TAG_WIDTH   = NLINE_WIDTH - SET_WIDTH,
    localparam int unsigned WAY_WIDTH   = (WAYS > 1) ? $clog2(WAYS) : 1
) (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,
    // Check a line against the pending misses
    input  wire logic                   check_i,
    input  wire logic [SET_WIDTH-1:0]   check_set_i,
    input  wire logic [TAG_WIDTH-1:0]   check_tag_i,
    output logic                        hit_o,
    // Store a new miss
    input  wire logic                   alloc_i,
    input  wire logic [NLINE_WIDTH-1:0] alloc_nline_i,
    input  wire logic [ID_WIDTH-1:0]    alloc_id_i,
    output logic                        alloc_full_o,
    output logic [WAY_WIDTH-1:0]        alloc_way_o,
    // Refill acknowledge, frees a slot
    input  wire logic                   ack_i,
    input  wire logic [SET_WIDTH-1:0]   ack_set_i,
    input  wire logic [WAY_WIDTH-1:0]   ack_way_i,
    output logic                        ack_valid_o,
    output logic [NLINE_WIDTH-1:0]      ack_nline_o,
    output logic [ID_WIDTH-1:0]         ack_id_o,
    output logic                        empty_o,
    output logic                        full_o,
    mshr_mem_if.ctrl                    mem
);

    logic [SETS-1:0][WAYS-1:0]   valid_q;
    logic [SET_WIDTH-1:0]        alloc_set;
    logic [TAG_WIDTH-1:0]        alloc_tag;
    logic [SET_WIDTH-1:0]        check_set_q;
    logic [SET_WIDTH-1:0]        ack_set_q;
    logic [WAY_WIDTH-1:0]        ack_way_q;
    logic [WAYS-1:0]             hit_way;
    mshr_types_pkg::mshr_entry_t ack_entry;

    assign alloc_set = alloc_nline_i[SET_WIDTH-1:0];
    assign alloc_tag = alloc_nline_i[NLINE_WIDTH-1:SET_WIDTH];

    // Bank port: acknowledge wins over allocate, allocate over check
    assign mem.cs     = ack_i | alloc_i | check_i;
    assign mem.we     = alloc_i & ~ack_i;
    assign mem.addr   = ack_i ? ack_set_i : (alloc_i ? alloc_set : check_set_i);
    assign mem.wway   = alloc_way_o;
    assign mem.wentry = '{tag: alloc_tag, req_id: alloc_id_i};

    // Lowest-numbered invalid way of the allocated set
    always_comb begin
        logic found;
        found       = 1'b0;
        alloc_way_o = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (!found && !valid_q[alloc_set][w]) begin
                found       = 1'b1;
                alloc_way_o = WAY_WIDTH'(w);
            end
        end
    end

    // Hit and full refer to the set checked on the previous cycle
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            hit_way[w] = valid_q[check_set_q][w] && (mem.rentry[w].tag == check_tag_i);
        end
    end

    assign hit_o        = |hit_way;
    assign alloc_full_o = &valid_q[check_set_q];

    // Refill read-out, line number rebuilt from tag and set
    assign ack_entry   = mem.rentry[ack_way_q];
    assign ack_nline_o = {ack_entry.tag, ack_set_q};
    assign ack_id_o    = ack_entry.req_id;

    assign empty_o = ~|valid_q;
    assign full_o  = &valid_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q     <= '0;
            check_set_q <= '0;
            ack_valid_o <= 1'b0;
        end else begin
            ack_valid_o <= ack_i;
            if (ack_i) begin
                valid_q[ack_set_i][ack_way_i] <= 1'b0;
            end
            if (alloc_i && !ack_i) begin
                valid_q[alloc_set][alloc_way_o] <= 1'b1;
            end
            if (check_i && !alloc_i && !ack_i) begin
                check_set_q <= check_set_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (ack_i) begin
            ack_set_q <= ack_set_i;
            ack_way_q <= ack_way_i;
        end
    end

    ack_alone_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        ack_i |-> !(alloc_i || check_i)
    ) else $error("MSHR acknowledge together with allocate or check");

    // The cycle after a check belongs to the pending decision
    ack_after_check_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        check_i |=> !ack_i
    ) else $error("MSHR acknowledge while a check result is pending");

endmodule

`default_nettype wire

// ==== rtl/mshr_cfg_pkg.sv ====
// MSHR geometry: default sets and ways, line number and requester id widths
`default_nettype none

package mshr_cfg_pkg;

    // Number of MSHR sets, a power of two of at least 2
    localparam int unsigned MSHR_SETS = 4;

    // Number of ways per set
    localparam int unsigned MSHR_WAYS = 2;

    // Cache line number, the set index sits in the low bits
    localparam int unsigned NLINE_WIDTH = 12;

    // Requester id returned with the refill acknowledge
    localparam int unsigned REQ_ID_WIDTH = 4;

    // Stored tag is whatever the set index leaves of the line number
    localparam int unsigned MSHR_TAG_WIDTH = NLINE_WIDTH - $clog2(MSHR_SETS);

endpackage

`default_nettype wire

// ==== rtl/mshr_mem_if.sv ====
// MSHR entry bank access: one address, per-way write select, whole-row read back
`default_nettype none

interface mshr_mem_if #(
    parameter int unsigned SETS = mshr_cfg_pkg::MSHR_SETS,
    parameter int unsigned WAYS = mshr_cfg_pkg::MSHR_WAYS
);
    localparam int unsigned SET_WIDTH = $clog2(SETS);
    localparam int unsigned WAY_WIDTH = (WAYS > 1) ? $clog2(WAYS) : 1;

    logic                 cs;
    logic                 we;
    logic [SET_WIDTH-1:0] addr;
    logic [WAY_WIDTH-1:0] wway;
    mshr_types_pkg::mshr_entry_t wentry;

    // All ways of the addressed row, one cycle after cs
    mshr_types_pkg::mshr_entry_t [WAYS-1:0] rentry;

    modport ctrl (output cs, we, addr, wway, wentry, input rentry);

    modport mem (input cs, we, addr, wway, wentry, output rentry);

endinterface

`default_nettype wire

// ==== rtl/mshr_regbank.sv ====
// MSHR entry bank: one row of ways per set, single port, registered row read
`default_nettype none

module mshr_regbank #(
    parameter int unsigned SETS = mshr_cfg_pkg::MSHR_SETS,
    parameter int unsigned WAYS = mshr_cfg_pkg::MSHR_WAYS
) (
    input  wire logic clk_i,
    input  wire logic rst_ni,
    mshr_mem_if.mem   mem
);

    // Storage rows, indexed by set
    mshr_types_pkg::mshr_entry_t [WAYS-1:0] rows_q [SETS];

    always_ff @(posedge clk_i) begin
        if (mem.cs) begin
            // Only the selected way of the row changes
            if (mem.we) begin
                rows_q[mem.addr][mem.wway] <= mem.wentry;
            end
            // Read returns the row as it was before this edge
            mem.rentry <= rows_q[mem.addr];
        end
    end

    // Free-way search in the MSHR must never point past the last way
    way_in_range_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (mem.cs && mem.we) |-> (int'(mem.wway) < int'(WAYS))
    ) else $error("MSHR bank write to way %0d, only %0d ways", mem.wway, WAYS);

endmodule

`default_nettype wire

// ==== rtl/mshr_types_pkg.sv ====
// MSHR types: stored entry layout, miss controller states and miss outcome codes
`default_nettype none

package mshr_types_pkg;

    // Field widths follow the configured geometry
    localparam int unsigned TAG_WIDTH = mshr_cfg_pkg::MSHR_TAG_WIDTH;
    localparam int unsigned ID_WIDTH  = mshr_cfg_pkg::REQ_ID_WIDTH;

    // One outstanding miss, the set is implied by the row it lives in
    typedef struct packed {
        logic [TAG_WIDTH-1:0] tag;
        logic [ID_WIDTH-1:0]  req_id;
    } mshr_entry_t;

    // Miss controller FSM
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        CHECK  = 2'd1,
        DECIDE = 2'd2
    } miss_state_e;

    // Outcome reported with done
    typedef enum logic [1:0] {
        MISS_ALLOC = 2'd0,
        MISS_HIT   = 2'd1,
        MISS_FULL  = 2'd2
    } miss_status_e;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f build.f --top-module tb_miss_unit \
    -Mdir obj_dir -o sim_miss_unit

./obj_dir/sim_miss_unit > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test passed" sim.log; then
    exit 0
else
    exit 1
fi

// ==== tests/miss_stim.txt ====
# M nline(hex) id(hex) status way : miss request, way is checked for ALLOC only
# R set way nline(hex) id(hex) : refill of a slot and its expected read-out
# E empty full : whole-MSHR flags
E 1 0
# Set 0 fills way 0 then way 1
M 010 1 ALLOC 0
M 020 2 ALLOC 1
# Pending line and full set
M 010 3 HIT 0
M 030 4 FULL 0
# Other set still allocates
M 005 5 ALLOC 0
M 005 6 HIT 0
M 0A5 7 ALLOC 1
# Free set 0 way 1 and reuse it
R 0 1 020 2
M 020 9 ALLOC 1
E 0 0
# Fill the remaining sets
M 0F2 A ALLOC 0
M 3C6 B ALLOC 1
M 7F3 C ALLOC 0
M FFF D ALLOC 1
E 0 1
M 100 E FULL 0
# Drain every slot
R 0 0 010 1
R 0 1 020 9
E 0 0
R 1 0 005 5
R 1 1 0A5 7
R 2 0 0F2 A
R 2 1 3C6 B
R 3 0 7F3 C
R 3 1 FFF D
E 1 0
M FFF 0 ALLOC 0
E 0 0
R 3 0 FFF 0
E 1 0

// ==== tests/tb_miss_unit.sv ====
// Miss unit testbench that replays the stimulus file against the top level and checks results
`default_nettype none

module tb_miss_unit;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned SETS        = mshr_cfg_pkg::MSHR_SETS;
    localparam int unsigned WAYS        = mshr_cfg_pkg::MSHR_WAYS;
    localparam int unsigned NLINE_WIDTH = mshr_cfg_pkg::NLINE_WIDTH;
    localparam int unsigned ID_WIDTH    = mshr_cfg_pkg::REQ_ID_WIDTH;
    localparam int unsigned SET_WIDTH   = $clog2(SETS);
    localparam int unsigned WAY_WIDTH   = (WAYS > 1) ? $clog2(WAYS) : 1;

    // Cycle limits for the handshake waits
    localparam int MISS_TIMEOUT = 20;
    localparam int ACK_TIMEOUT  = 4;

    // Edges from the miss strobe to done_o
    localparam int DONE_EDGES = 3;
    // Edges from the refill strobe to ack_valid_o
    localparam int ACK_EDGES  = 1;

    // Stimulus file tokens
    localparam logic [63:0] OP_MISS    = 64'("M");
    localparam logic [63:0] OP_REFILL  = 64'("R");
    localparam logic [63:0] OP_FLAGS   = 64'("E");
    localparam logic [63:0] OP_COMMENT = 64'("#");
    localparam logic [63:0] ST_ALLOC   = 64'("ALLOC");
    localparam logic [63:0] ST_HIT     = 64'("HIT");
    localparam logic [63:0] ST_FULL    = 64'("FULL");

    logic                         clk_i;
    logic                         rst_ni;
    logic                         miss_req_i;
    logic [NLINE_WIDTH-1:0]       miss_nline_i;
    logic [ID_WIDTH-1:0]          miss_id_i;
    logic                         busy_o;
    logic                         done_o;
    mshr_types_pkg::miss_status_e status_o;
    logic [WAY_WIDTH-1:0]         way_o;
    logic                         refill_i;
    logic [SET_WIDTH-1:0]         refill_set_i;
    logic [WAY_WIDTH-1:0]         refill_way_i;
    logic                         ack_valid_o;
    logic [NLINE_WIDTH-1:0]       ack_nline_o;
    logic [ID_WIDTH-1:0]          ack_id_o;
    logic                         empty_o;
    logic                         full_o;

    miss_unit_top #(.SETS(SETS), .WAYS(WAYS)) u_miss_unit_top (
        .clk_i, .rst_ni,
        .miss_req_i, .miss_nline_i, .miss_id_i, .busy_o,
        .done_o, .status_o, .way_o,
        .refill_i, .refill_set_i, .refill_way_i,
        .ack_valid_o, .ack_nline_o, .ack_id_o,
        .empty_o, .full_o
    );

    always #4 clk_i = ~clk_i;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "Simulation stopped after an error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_run($sformatf("CHECK FAILED at %0t ns: %s is 0x%0h, expected 0x%0h",
                               $time, name, actual, expected));
        end
    endtask

    task automatic decode_status(input logic [63:0] txt,
                                 output mshr_types_pkg::miss_status_e code);
        code = mshr_types_pkg::MISS_ALLOC;
        if (txt == ST_ALLOC) begin
            code = mshr_types_pkg::MISS_ALLOC;
        end else if (txt == ST_HIT) begin
            code = mshr_types_pkg::MISS_HIT;
        end else if (txt == ST_FULL) begin
            code = mshr_types_pkg::MISS_FULL;
        end else begin
            stop_run("Unknown status name in the stimulus file");
        end
    endtask

    // One miss strobe and the wait for done while busy stays high
    task automatic run_miss(input int nline, input int id,
                            input mshr_types_pkg::miss_status_e exp_status, input int exp_way);
        int edges;
        edges = 1;
        @(posedge clk_i);
        #1;
        miss_req_i   = 1'b1;
        miss_nline_i = NLINE_WIDTH'(nline);
        miss_id_i    = ID_WIDTH'(id);
        @(posedge clk_i);
        #1;
        miss_req_i = 1'b0;
        @(negedge clk_i);
        while (!done_o) begin
            check_value("busy_o", 32'(busy_o), 1);
            edges++;
            if (edges > MISS_TIMEOUT) begin
                stop_run("Timeout: done_o never rose after a miss request");
            end
            @(negedge clk_i);
        end
        check_value("done_o delay", 32'(edges), DONE_EDGES);
        check_value("busy_o", 32'(busy_o), 0);
        check_value("status_o", 32'(status_o), 32'(exp_status));
        // Way only means something for a stored miss
        if (exp_status == mshr_types_pkg::MISS_ALLOC) begin
            check_value("way_o", 32'(way_o), exp_way);
        end
        @(negedge clk_i);
        check_value("done_o", 32'(done_o), 0);
    endtask

    task automatic run_refill(input int set, input int way, input int exp_nline, input int exp_id);
        int edges;
        edges = 1;
        @(posedge clk_i);
        #1;
        refill_i     = 1'b1;
        refill_set_i = SET_WIDTH'(set);
        refill_way_i = WAY_WIDTH'(way);
        @(posedge clk_i);
        #1;
        refill_i = 1'b0;
        @(negedge clk_i);
        while (!ack_valid_o) begin
            edges++;
            if (edges > ACK_TIMEOUT) begin
                stop_run("Timeout: ack_valid_o never rose after a refill");
            end
            @(negedge clk_i);
        end
        check_value("ack_valid_o delay", 32'(edges), ACK_EDGES);
        check_value("ack_nline_o", 32'(ack_nline_o), exp_nline);
        check_value("ack_id_o", 32'(ack_id_o), exp_id);
        @(negedge clk_i);
        check_value("ack_valid_o", 32'(ack_valid_o), 0);
    endtask

    task automatic check_flags(input int exp_empty, input int exp_full);
        @(negedge clk_i);
        check_value("empty_o", 32'(empty_o), exp_empty);
        check_value("full_o", 32'(full_o), exp_full);
    endtask

    task automatic check_reset_state();
        @(negedge clk_i);
        check_value("empty_o", 32'(empty_o), 1);
        check_value("full_o", 32'(full_o), 0);
        check_value("busy_o", 32'(busy_o), 0);
        check_value("done_o", 32'(done_o), 0);
        check_value("ack_valid_o", 32'(ack_valid_o), 0);
    endtask

    task automatic replay_stimulus();
        int fd;
        int n;
        int a;
        int b;
        int c;
        int d;
        int commands;
        logic [63:0] op;
        logic [63:0] st_txt;
        logic [8*160-1:0] line_rest;
        mshr_types_pkg::miss_status_e exp_status;
        commands = 0;
        fd = $fopen("tests/miss_stim.txt", "r");
        if (fd == 0) begin
            stop_run("Cannot open the stimulus file tests/miss_stim.txt");
        end
        n = $fscanf(fd, "%s", op);
        while (n == 1) begin
            if (op != OP_COMMENT) begin
                commands++;
            end
            if (op == OP_COMMENT) begin
                n = $fgets(line_rest, fd);
            end else if (op == OP_MISS) begin
                n = $fscanf(fd, "%h %h %s %d", a, b, st_txt, c);
                if (n != 4) begin
                    stop_run("Malformed miss line in the stimulus file");
                end
                decode_status(st_txt, exp_status);
                run_miss(a, b, exp_status, c);
            end else if (op == OP_REFILL) begin
                n = $fscanf(fd, "%d %d %h %h", a, b, c, d);
                if (n != 4) begin
                    stop_run("Malformed refill line in the stimulus file");
                end
                run_refill(a, b, c, d);
            end else if (op == OP_FLAGS) begin
                n = $fscanf(fd, "%d %d", a, b);
                if (n != 2) begin
                    stop_run("Malformed flag line in the stimulus file");
                end
                check_flags(a, b);
            end else begin
                stop_run("Unknown opcode in the stimulus file");
            end
            n = $fscanf(fd, "%s", op);
        end
        $fclose(fd);
        if (commands == 0) begin
            stop_run("The stimulus file holds no commands");
        end
    endtask

    initial begin
        clk_i        = 1'b0;
        rst_ni       = 1'b0;
        miss_req_i   = 1'b0;
        miss_nline_i = '0;
        miss_id_i    = '0;
        refill_i     = 1'b0;
        refill_set_i = '0;
        refill_way_i = '0;
        repeat (2) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        check_reset_state();
        replay_stimulus();
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire
